// ==== verilog/mem_uart_params.svh ====
// Sizes shared by the memory UART bridge and its testbench
// Data and address widths must be multiples of 4 and at least 8
// MEM_CLKS_PER_BIT must be at least 2, and 16 only suits simulation
// For hardware set it to the clock rate divided by the baud rate
// MEM_FIFO_DEPTH must be a power of two

`ifndef MEM_UART_PARAMS_SVH
`define MEM_UART_PARAMS_SVH

////////////////////
// Word sizes
////////////////////

`define MEM_DATA_WIDTH 32
`define MEM_ADDR_WIDTH 32

////////////////////
// Serial link and buffering
////////////////////

// Clock cycles per UART bit
`define MEM_CLKS_PER_BIT 16

// Bytes buffered between framer and transmitter
`define MEM_FIFO_DEPTH 8

`endif

// ==== verilog/mem_uart_pkg.sv ====
// Types shared by the bridge blocks
// One UART byte is a data nibble in the upper half and a one-hot
// command in the lower half

`default_nettype none

`include "mem_uart_params.svh"

package mem_uart_pkg;

   ////////////////////
   // Frame sizes
   ////////////////////

   // Nibbles per word and per address
   localparam int DATA_NIBBLES = `MEM_DATA_WIDTH / 4;
   localparam int ADDR_NIBBLES = `MEM_ADDR_WIDTH / 4;

   ////////////////////
   // Byte layout
   ////////////////////

   // One-hot command nibble, zero means mid transmission
   typedef enum logic [3:0] {
      CMD_TRANS      = 4'b0000,
      CMD_DATA_START = 4'b0001,
      CMD_ADDR_START = 4'b0010,
      CMD_END_WRITE  = 4'b0100,
      CMD_END_READ   = 4'b1000
   } cmd_t;

   // Nibble sits in bits 7:4, command in bits 3:0
   typedef struct packed {
      logic [3:0] nibble;
      cmd_t       cmd;
   } frame_t;

endpackage

`default_nettype wire

// ==== verilog/request_framer.sv ====
// Serializes one read or write request into command-tagged nibble bytes
// Only one request is handled at a time, a read blocks until its data returns
// Address and data are captured when the request is taken

`timescale 1ns/1ps
`default_nettype none

`include "mem_uart_params.svh"

module request_framer (
   input  wire                         i_clk,
   input  wire                         i_nRst,
   input  wire                         i_read_valid,
   input  wire                         i_write_valid,
   input  wire [`MEM_ADDR_WIDTH-1:0]   i_addr,
   input  wire [`MEM_DATA_WIDTH-1:0]   i_data,
   input  wire                         i_full,
   input  wire                         i_read_done,
   output logic                        o_push,
   output mem_uart_pkg::frame_t        o_frame,
   output logic                        o_write_accept,
   output logic                        o_read_accept
);

   import mem_uart_pkg::*;

   localparam int TOTAL_NIBBLES = ADDR_NIBBLES + DATA_NIBBLES;
   localparam int PTR_W         = $clog2(TOTAL_NIBBLES);

   // Pointer positions that change the command
   localparam logic [PTR_W-1:0] READ_LAST  = PTR_W'(ADDR_NIBBLES - 1);
   localparam logic [PTR_W-1:0] DATA_FIRST = PTR_W'(ADDR_NIBBLES);
   localparam logic [PTR_W-1:0] WRITE_LAST = PTR_W'(TOTAL_NIBBLES - 1);

   typedef enum logic [1:0] {
      S_IDLE,
      S_SEND,
      S_WAIT_READ
   } state_t;

   state_t                                   state_q;
   logic [PTR_W-1:0]                         ptr_q;
   logic                                     is_read_q;
   logic [`MEM_DATA_WIDTH+`MEM_ADDR_WIDTH-1:0] word_q;
   logic [3:0]                               cur_nibble;
   cmd_t                                     cur_cmd;
   logic                                     last_byte;

   // Address sits below data so one pointer walks both in order
   assign cur_nibble = word_q[{ptr_q, 2'b00} +: 4];

   always_comb begin
      if (ptr_q == '0) begin
         cur_cmd = CMD_ADDR_START;
      end else if (is_read_q) begin
         cur_cmd = (ptr_q == READ_LAST) ? CMD_END_READ : CMD_TRANS;
      end else if (ptr_q == DATA_FIRST) begin
         cur_cmd = CMD_DATA_START;
      end else if (ptr_q == WRITE_LAST) begin
         cur_cmd = CMD_END_WRITE;
      end else begin
         cur_cmd = CMD_TRANS;
      end
   end

   assign last_byte = (ptr_q == (is_read_q ? READ_LAST : WRITE_LAST));

   assign o_frame        = '{nibble: cur_nibble, cmd: cur_cmd};
   assign o_push         = (state_q == S_SEND) && !i_full;
   assign o_write_accept = o_push && last_byte && !is_read_q;
   assign o_read_accept  = (state_q == S_WAIT_READ) && i_read_done;

   always_ff @(posedge i_clk or negedge i_nRst) begin
      if (!i_nRst) begin
         state_q   <= S_IDLE;
         ptr_q     <= '0;
         is_read_q <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               // Read takes priority when both are requested
               if (i_read_valid || i_write_valid) begin
                  state_q   <= S_SEND;
                  ptr_q     <= '0;
                  is_read_q <= i_read_valid;
               end
            end
            S_SEND: begin
               if (o_push) begin
                  if (last_byte) begin
                     state_q <= is_read_q ? S_WAIT_READ : S_IDLE;
                  end else begin
                     ptr_q <= ptr_q + 1'b1;
                  end
               end
            end
            S_WAIT_READ: begin
               if (i_read_done) begin
                  state_q <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // Request capture
   always_ff @(posedge i_clk) begin
      if (state_q == S_IDLE) begin
         word_q <= {i_data, i_addr};
      end
   end

endmodule

`default_nettype wire

// ==== verilog/frame_fifo.sv ====
// Byte FIFO between the framer and the UART transmitter
// Push when full and pop when empty are dropped
// Read data is combinational from the head entry

`timescale 1ns/1ps
`default_nettype none

`include "mem_uart_params.svh"

module frame_fifo (
   input  wire                   i_clk,
   input  wire                   i_nRst,
   input  wire                   i_push,
   input  wire mem_uart_pkg::frame_t i_frame,
   input  wire                   i_pop,
   output mem_uart_pkg::frame_t  o_frame,
   output logic                  o_full,
   output logic                  o_empty
);

   import mem_uart_pkg::*;

   localparam int DEPTH = `MEM_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   frame_t        mem [DEPTH];
   logic [AW:0]   wr_ptr_q;
   logic [AW:0]   rd_ptr_q;
   logic          do_push;
   logic          do_pop;

   // Extra pointer bit tells a full buffer from an empty one
   assign o_empty = (wr_ptr_q == rd_ptr_q);
   assign o_full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                    (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

   assign do_push = i_push && !o_full;
   assign do_pop  = i_pop && !o_empty;

   assign o_frame = mem[rd_ptr_q[AW-1:0]];

   always_ff @(posedge i_clk or negedge i_nRst) begin
      if (!i_nRst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // Storage
   always_ff @(posedge i_clk) begin
      if (do_push) begin
         mem[wr_ptr_q[AW-1:0]] <= i_frame;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
// 8N1 transmitter, LSB first, fed from the frame FIFO
// Each byte takes exactly 10 bit times, back to back bytes have no idle gap
// Line idles high

`timescale 1ns/1ps
`default_nettype none

`include "mem_uart_params.svh"

module uart_tx (
   input  wire                   i_clk,
   input  wire                   i_nRst,
   input  wire                   i_empty,
   input  wire mem_uart_pkg::frame_t i_frame,
   output logic                  o_pop,
   output logic                  o_tx
);

   localparam int CLKS = `MEM_CLKS_PER_BIT;
   localparam int CW   = $clog2(CLKS);

   logic [CW-1:0] baud_cnt_q;
   logic [3:0]    bit_cnt_q;
   logic [9:0]    shift_q;
   logic          busy_q;
   logic          bit_end;
   logic          frame_end;

   assign bit_end   = busy_q && (baud_cnt_q == CW'(CLKS - 1));
   assign frame_end = bit_end && (bit_cnt_q == 4'd9);

   // Next byte may load during the last cycle of the stop bit
   assign o_pop = (!busy_q || frame_end) && !i_empty;
   assign o_tx  = shift_q[0];

   always_ff @(posedge i_clk or negedge i_nRst) begin
      if (!i_nRst) begin
         baud_cnt_q <= '0;
         bit_cnt_q  <= '0;
         shift_q    <= '1;
         busy_q     <= 1'b0;
      end else if (o_pop) begin
         // Stop bit, byte, start bit
         shift_q    <= {1'b1, i_frame, 1'b0};
         baud_cnt_q <= '0;
         bit_cnt_q  <= '0;
         busy_q     <= 1'b1;
      end else if (frame_end) begin
         busy_q <= 1'b0;
      end else if (bit_end) begin
         baud_cnt_q <= '0;
         bit_cnt_q  <= bit_cnt_q + 1'b1;
         shift_q    <= {1'b1, shift_q[9:1]};
      end else if (busy_q) begin
         baud_cnt_q <= baud_cnt_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/uart_rx.sv ====
// 8N1 receiver, LSB first, sampling each bit at its midpoint
// A start bit that is high again at mid-bit, or a low stop bit, drops the byte
// o_byte_valid pulses at the middle of the stop bit

`timescale 1ns/1ps
`default_nettype none

`include "mem_uart_params.svh"

module uart_rx (
   input  wire                   i_clk,
   input  wire                   i_nRst,
   input  wire                   i_rx,
   output mem_uart_pkg::frame_t  o_byte,
   output logic                  o_byte_valid
);

   import mem_uart_pkg::*;

   localparam int CLKS = `MEM_CLKS_PER_BIT;
   localparam int CW   = $clog2(CLKS);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t     state_q;
   logic          rx_meta_q;
   logic          rx_sync_q;
   logic          rx_prev_q;
   logic [CW-1:0] cnt_q;
   logic [2:0]    bit_cnt_q;
   logic [7:0]    data_q;
   logic          half_bit;
   logic          full_bit;

   assign half_bit = (cnt_q == CW'(CLKS / 2 - 1));
   assign full_bit = (cnt_q == CW'(CLKS - 1));

   assign o_byte = frame_t'(data_q);

   // Input synchronizer plus one stage for edge detection
   always_ff @(posedge i_clk or negedge i_nRst) begin
      if (!i_nRst) begin
         rx_meta_q <= 1'b1;
         rx_sync_q <= 1'b1;
         rx_prev_q <= 1'b1;
      end else begin
         rx_meta_q <= i_rx;
         rx_sync_q <= rx_meta_q;
         rx_prev_q <= rx_sync_q;
      end
   end

   always_ff @(posedge i_clk or negedge i_nRst) begin
      if (!i_nRst) begin
         state_q      <= RX_IDLE;
         cnt_q        <= '0;
         bit_cnt_q    <= '0;
         o_byte_valid <= 1'b0;
      end else begin
         o_byte_valid <= 1'b0;
         cnt_q        <= cnt_q + 1'b1;
         case (state_q)
            RX_IDLE: begin
               cnt_q <= '0;
               if (rx_prev_q && !rx_sync_q) begin
                  state_q <= RX_START;
               end
            end
            RX_START: begin
               if (half_bit) begin
                  // From here on cnt_q runs in bit periods centred mid-bit
                  cnt_q     <= '0;
                  bit_cnt_q <= '0;
                  state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (full_bit) begin
                  cnt_q     <= '0;
                  bit_cnt_q <= bit_cnt_q + 1'b1;
                  if (bit_cnt_q == 3'd7) begin
                     state_q <= RX_STOP;
                  end
               end
            end
            RX_STOP: begin
               if (full_bit) begin
                  o_byte_valid <= rx_sync_q;
                  state_q      <= RX_IDLE;
               end
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

   // Data bits shift in from the top
   always_ff @(posedge i_clk) begin
      if (state_q == RX_DATA && full_bit) begin
         data_q <= {rx_sync_q, data_q[7:1]};
      end
   end

endmodule

`default_nettype wire

// ==== verilog/read_collector.sv ====
// Builds the read response word from received nibble bytes, LSB first
// Mid transmission bytes are ignored until a start of data byte is seen
// A new start of data byte always restarts the word

`timescale 1ns/1ps
`default_nettype none

`include "mem_uart_params.svh"

module read_collector (
   input  wire                         i_clk,
   input  wire                         i_nRst,
   input  wire mem_uart_pkg::frame_t   i_byte,
   input  wire                         i_byte_valid,
   output logic [`MEM_DATA_WIDTH-1:0]  o_data,
   output logic                        o_read_done
);

   import mem_uart_pkg::*;

   localparam int                W      = `MEM_DATA_WIDTH;
   localparam int                CW     = $clog2(DATA_NIBBLES + 1);
   localparam logic [CW-1:0]     N_LAST = CW'(DATA_NIBBLES);

   logic [W-1:0]  word_q;
   logic [W-1:0]  word_next;
   logic [CW-1:0] cnt_q;
   logic [CW-1:0] cnt_next;
   logic          take;

   assign word_next = {i_byte.nibble, word_q[W-1:4]};

   // Zero count means no response in progress
   always_comb begin
      take     = 1'b0;
      cnt_next = cnt_q;
      if (i_byte_valid) begin
         if (i_byte.cmd == CMD_DATA_START) begin
            take     = 1'b1;
            cnt_next = CW'(1);
         end else if (i_byte.cmd == CMD_TRANS && cnt_q != '0) begin
            take     = 1'b1;
            cnt_next = cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_nRst) begin
      if (!i_nRst) begin
         cnt_q       <= '0;
         o_data      <= '0;
         o_read_done <= 1'b0;
      end else begin
         o_read_done <= 1'b0;
         if (take) begin
            if (cnt_next == N_LAST) begin
               cnt_q       <= '0;
               o_data      <= word_next;
               o_read_done <= 1'b1;
            end else begin
               cnt_q <= cnt_next;
            end
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (take) begin
         word_q <= word_next;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/mem_uart.sv ====
// Memory emulator bridge, parallel requests out over UART to a host script
// Requester holds valid, address and data until the matching accept
// o_data holds the last read word until the next read completes

`timescale 1ns/1ps
`default_nettype none

`include "mem_uart_params.svh"

module mem_uart (
   input  wire                         i_clk,
   input  wire                         i_nRst,
   input  wire [`MEM_ADDR_WIDTH-1:0]   i_addr,
   input  wire [`MEM_DATA_WIDTH-1:0]   i_data,
   input  wire                         i_read_valid,
   input  wire                         i_write_valid,
   output logic [`MEM_DATA_WIDTH-1:0]  o_data,
   output logic                        o_read_accept,
   output logic                        o_write_accept,
   input  wire                         i_uart_rx,
   output logic                        o_uart_tx
);

   import mem_uart_pkg::*;

   frame_t push_frame;
   frame_t head_frame;
   frame_t rx_byte;
   logic   push;
   logic   pop;
   logic   full;
   logic   empty;
   logic   rx_valid;
   logic   read_done;

   ////////////////////
   // Transmit path
   ////////////////////

   request_framer framer_i (
      .i_clk          (i_clk),
      .i_nRst         (i_nRst),
      .i_read_valid   (i_read_valid),
      .i_write_valid  (i_write_valid),
      .i_addr         (i_addr),
      .i_data         (i_data),
      .i_full         (full),
      .i_read_done    (read_done),
      .o_push         (push),
      .o_frame        (push_frame),
      .o_write_accept (o_write_accept),
      .o_read_accept  (o_read_accept)
   );

   frame_fifo fifo_i (
      .i_clk   (i_clk),
      .i_nRst  (i_nRst),
      .i_push  (push),
      .i_frame (push_frame),
      .i_pop   (pop),
      .o_frame (head_frame),
      .o_full  (full),
      .o_empty (empty)
   );

   uart_tx tx_i (
      .i_clk   (i_clk),
      .i_nRst  (i_nRst),
      .i_empty (empty),
      .i_frame (head_frame),
      .o_pop   (pop),
      .o_tx    (o_uart_tx)
   );

   ////////////////////
   // Receive path
   ////////////////////

   uart_rx rx_i (
      .i_clk        (i_clk),
      .i_nRst       (i_nRst),
      .i_rx         (i_uart_rx),
      .o_byte       (rx_byte),
      .o_byte_valid (rx_valid)
   );

   read_collector collector_i (
      .i_clk        (i_clk),
      .i_nRst       (i_nRst),
      .i_byte       (rx_byte),
      .i_byte_valid (rx_valid),
      .o_data       (o_data),
      .o_read_done  (read_done)
   );

endmodule

`default_nettype wire

// ==== tests/mem_uart_assertions.sv ====
// Protocol checks bound onto the bridge top level
// All checks are idle while the active low reset is asserted

`timescale 1ns/1ps
`default_nettype none

module mem_uart_assertions (
   input wire i_clk,
   input wire i_nRst,
   input wire i_read_valid,
   input wire i_pop,
   input wire i_tx,
   input wire i_read_accept,
   input wire i_write_accept
);

   logic popped_q;
   logic read_pending_q;

   always_ff @(posedge i_clk or negedge i_nRst) begin
      if (!i_nRst) begin
         popped_q       <= 1'b0;
         read_pending_q <= 1'b0;
      end else begin
         if (i_pop) begin
            popped_q <= 1'b1;
         end
         // Cleared at the accept and set again by the next request
         if (i_read_accept) begin
            read_pending_q <= 1'b0;
         end else if (i_read_valid) begin
            read_pending_q <= 1'b1;
         end
      end
   end

   tx_idle_until_pop: assert property (@(posedge i_clk) disable iff (!i_nRst)
      !popped_q |-> i_tx) else $error("transmit line went low before the first byte");

   accepts_exclusive: assert property (@(posedge i_clk) disable iff (!i_nRst)
      !(i_read_accept && i_write_accept)) else $error("read and write accepts together");

   read_accept_single: assert property (@(posedge i_clk) disable iff (!i_nRst)
      i_read_accept |=> !i_read_accept) else $error("read accept longer than one cycle");

   write_accept_single: assert property (@(posedge i_clk) disable iff (!i_nRst)
      i_write_accept |=> !i_write_accept) else $error("write accept longer than one cycle");

   read_accept_requested: assert property (@(posedge i_clk) disable iff (!i_nRst)
      i_read_accept |-> read_pending_q) else $error("read accept without a read request");

endmodule

bind mem_uart mem_uart_assertions assertions_i (
   .i_clk          (i_clk),
   .i_nRst         (i_nRst),
   .i_read_valid   (i_read_valid),
   .i_pop          (pop),
   .i_tx           (o_uart_tx),
   .i_read_accept  (o_read_accept),
   .i_write_accept (o_write_accept)
);

`default_nettype wire

// ==== tests/tb_mem_uart.sv ====
// Testbench for the memory UART bridge
// A script model decodes the transmit line, keeps a sparse memory and answers
// reads on the receive line. Expected bytes and read data come from the
// frame-order rule and a reference memory kept by the stimulus.
// Stops at the first error. A cycle limit bounds the run.

`timescale 1ns/1ps
`default_nettype none

`include "mem_uart_params.svh"

module tb_mem_uart;

   import mem_uart_pkg::*;

   localparam int DW       = `MEM_DATA_WIDTH;
   localparam int AW       = `MEM_ADDR_WIDTH;
   localparam int CLKS     = `MEM_CLKS_PER_BIT;
   localparam int N_RANDOM = 200;
   localparam int N_BURST  = 4;
   localparam int N_OPS    = N_RANDOM + 2 * N_BURST + 3;
   localparam int TIMEOUT_CYCLES =
      N_OPS * (ADDR_NIBBLES + 2 * DATA_NIBBLES) * 10 * CLKS * 2;
   localparam logic [AW-1:0] ADDR_BASE = AW'(32'h5a3c_0100);

   logic          clk;
   logic          nRst;
   logic [AW-1:0] req_addr;
   logic [DW-1:0] req_data;
   logic          read_valid;
   logic          write_valid;
   logic [DW-1:0] rd_data;
   logic          read_accept;
   logic          write_accept;
   logic          uart_to_dut;
   logic          uart_from_dut;

   integer        seed = 32'hf312;
   int            cycle_cnt;
   int            writes_issued;
   int            accept_cnt;
   bit            inject_partial;

   // Expected transmit bytes, script state and memories
   frame_t        exp_frames[$];
   logic [AW-1:0] read_q[$];
   logic [DW-1:0] script_mem[logic [AW-1:0]];
   logic [DW-1:0] ref_mem[logic [AW-1:0]];
   logic [AW-1:0] s_addr;
   logic [DW-1:0] s_data;
   int            s_addr_cnt;
   int            s_data_cnt;
   bit            s_in_data;

   mem_uart mem_uart_i (
      .i_clk          (clk),
      .i_nRst         (nRst),
      .i_addr         (req_addr),
      .i_data         (req_data),
      .i_read_valid   (read_valid),
      .i_write_valid  (write_valid),
      .o_data         (rd_data),
      .o_read_accept  (read_accept),
      .o_write_accept (write_accept),
      .i_uart_rx      (uart_to_dut),
      .o_uart_tx      (uart_from_dut)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////
   // Error reporting
   ////////////////////

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                             input string what);
      if (got !== exp) begin
         fail_run($sformatf("mismatch at %0t: %s got %h expected %h",
                            $time, what, got, exp));
      end
   endtask

   task automatic check_frame(input frame_t got, input frame_t exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("mismatch at %0t: %s got %h expected %h",
                            $time, what, got, exp));
      end
   endtask

   task automatic check_cmd(input cmd_t got, input cmd_t exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("mismatch at %0t: %s got %s expected %s",
                            $time, what, got.name(), exp.name()));
      end
   endtask

   task automatic check_reset_state();
      if (uart_from_dut !== 1'b1 || read_accept !== 1'b0 || write_accept !== 1'b0) begin
         fail_run("transmit line or accept outputs not idle around reset");
      end
      check_word(rd_data, '0, "read data after reset");
   endtask

   ////////////////////
   // Script model
   ////////////////////

   // Byte sequence for one request, nibbles LSB first
   task automatic push_expected(input bit is_read, input logic [AW-1:0] addr,
                                input logic [DW-1:0] data);
      frame_t f;
      for (int i = 0; i < ADDR_NIBBLES; i++) begin
         f.nibble = addr[3:0];
         addr     = addr >> 4;
         if (i == 0) f.cmd = CMD_ADDR_START;
         else if (is_read && i == ADDR_NIBBLES - 1) f.cmd = CMD_END_READ;
         else f.cmd = CMD_TRANS;
         exp_frames.push_back(f);
      end
      for (int j = 0; j < DATA_NIBBLES && !is_read; j++) begin
         f.nibble = data[3:0];
         data     = data >> 4;
         if (j == 0) f.cmd = CMD_DATA_START;
         else if (j == DATA_NIBBLES - 1) f.cmd = CMD_END_WRITE;
         else f.cmd = CMD_TRANS;
         exp_frames.push_back(f);
      end
   endtask

   task automatic script_handle(input frame_t f);
      if (f.cmd == CMD_ADDR_START) begin
         s_addr_cnt = 0;
         s_data_cnt = 0;
         s_in_data  = 1'b0;
      end else if (f.cmd == CMD_DATA_START) begin
         s_in_data = 1'b1;
      end
      if (s_in_data) begin
         s_data = {f.nibble, s_data[DW-1:4]};
         s_data_cnt++;
      end else begin
         s_addr = {f.nibble, s_addr[AW-1:4]};
         s_addr_cnt++;
      end
      if (f.cmd == CMD_END_WRITE) begin
         if (s_addr_cnt != ADDR_NIBBLES || s_data_cnt != DATA_NIBBLES) begin
            fail_run("write frame arrived with the wrong number of nibbles");
         end
         script_mem[s_addr] = s_data;
      end else if (f.cmd == CMD_END_READ) begin
         if (s_addr_cnt != ADDR_NIBBLES) begin
            fail_run("read frame arrived with the wrong number of nibbles");
         end
         read_q.push_back(s_addr);
      end
   endtask

   // Sampled on the falling clock edge, away from DUT updates
   initial begin : serial_decoder
      frame_t     got;
      frame_t     exp;
      logic [7:0] bits;
      forever begin
         @(negedge clk);
         if (nRst === 1'b1 && uart_from_dut === 1'b0) begin
            repeat (CLKS / 2) @(negedge clk);
            if (uart_from_dut !== 1'b0) fail_run("start bit on the DUT transmit line was short");
            for (int i = 0; i < 8; i++) begin
               repeat (CLKS) @(negedge clk);
               bits = {uart_from_dut, bits[7:1]};
            end
            repeat (CLKS) @(negedge clk);
            if (uart_from_dut !== 1'b1) fail_run("stop bit on the DUT transmit line was low");
            got = frame_t'(bits);
            if (exp_frames.size() == 0) fail_run("DUT sent a byte with no request outstanding");
            exp = exp_frames.pop_front();
            check_cmd(got.cmd, exp.cmd, "transmit command");
            check_frame(got, exp, "transmit byte");
            script_handle(got);
         end
      end
   end

   // Caller starts just after a rising edge
   task automatic send_byte(input frame_t f);
      logic [9:0] bits;
      bits = {1'b1, f, 1'b0};
      for (int i = 0; i < 10; i++) begin
         uart_to_dut = bits[0];
         bits        = bits >> 1;
         repeat (CLKS) @(posedge clk);
         #2;
      end
   endtask

   task automatic send_word(input logic [DW-1:0] word, input int nibbles);
      frame_t f;
      for (int j = 0; j < nibbles; j++) begin
         f.nibble = word[3:0];
         f.cmd    = (j == 0) ? CMD_DATA_START : CMD_TRANS;
         word     = word >> 4;
         send_byte(f);
      end
   endtask

   initial begin : serial_encoder
      logic [AW-1:0] addr;
      logic [DW-1:0] word;
      uart_to_dut = 1'b1;
      forever begin
         while (read_q.size() == 0) @(posedge clk);
         #2;
         addr = read_q.pop_front();
         word = script_mem.exists(addr) ? script_mem[addr] : '0;
         // Half a response with other data, then the real one
         if (inject_partial) begin
            inject_partial = 1'b0;
            send_word(~word, DATA_NIBBLES / 2);
         end
         send_word(word, DATA_NIBBLES);
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic wait_accept(input bit is_read);
      do begin
         @(negedge clk);
      end while (!(is_read ? read_accept : write_accept));
      @(posedge clk);
      #2;
   endtask

   task automatic do_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
      push_expected(1'b0, addr, data);
      ref_mem[addr] = data;
      writes_issued++;
      req_addr    = addr;
      req_data    = data;
      write_valid = 1'b1;
      wait_accept(1'b0);
      write_valid = 1'b0;
   endtask

   task automatic do_read(input logic [AW-1:0] addr);
      logic [DW-1:0] exp;
      exp = ref_mem.exists(addr) ? ref_mem[addr] : '0;
      push_expected(1'b1, addr, '0);
      req_addr   = addr;
      read_valid = 1'b1;
      wait_accept(1'b1);
      read_valid = 1'b0;
      check_word(rd_data, exp, "read data");
   endtask

   initial begin : accept_counter
      accept_cnt = 0;
      forever begin
         @(negedge clk);
         if (write_accept === 1'b1) accept_cnt++;
      end
   end

   initial begin : watchdog
      cycle_cnt = 0;
      forever begin
         @(posedge clk);
         cycle_cnt++;
         if (cycle_cnt > TIMEOUT_CYCLES) fail_run("run did not finish within the cycle limit");
      end
   end

   initial begin : main
      logic [AW-1:0] addr;
      nRst           = 1'b0;
      read_valid     = 1'b0;
      write_valid    = 1'b0;
      req_addr       = '0;
      req_data       = '0;
      writes_issued  = 0;
      inject_partial = 1'b0;
      repeat (16) begin
         @(negedge clk);
         check_reset_state();
      end
      @(posedge clk);
      #2;
      nRst = 1'b1;
      repeat (4) begin
         @(negedge clk);
         check_reset_state();
      end
      @(posedge clk);
      #2;

      // Single write and read-back
      do_write(ADDR_BASE, DW'(32'hc0de_5a17));
      do_read(ADDR_BASE);

      // Back to back writes overflow the FIFO
      for (int i = 0; i < N_BURST; i++) begin
         do_write(ADDR_BASE | AW'(i + 1), DW'($random(seed)));
      end
      for (int i = 0; i < N_BURST; i++) begin
         do_read(ADDR_BASE | AW'(i + 1));
      end

      // Response restarted part way
      inject_partial = 1'b1;
      do_read(ADDR_BASE | AW'(2));

      for (int n = 0; n < N_RANDOM; n++) begin
         addr = ADDR_BASE | AW'($random(seed) & 15);
         if (($random(seed) & 1) != 0) do_read(addr);
         else do_write(addr, DW'($random(seed)));
      end

      while (exp_frames.size() != 0) @(posedge clk);
      if (accept_cnt != writes_issued) begin
         fail_run("write accept count differs from the number of writes issued");
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/mem_uart_pkg.sv
verilog/request_framer.sv
verilog/frame_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/read_collector.sv
verilog/mem_uart.sv
tests/mem_uart_assertions.sv
tests/tb_mem_uart.sv

// ==== Makefile ====
# Verilator build for the memory UART bridge testbench
# Override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_mem_uart
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Simulation PASSED$$" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
